// ==== sources.f ====
hw/bch_syn_pkg.sv
hw/syn_remainder.sv
hw/syn_expand.sv
hw/syn_bank.sv
hw/codeword_shifter.sv
hw/syn_wb_regs.sv
hw/bch_syn_top.sv
tb/syn_checker.sv
tb/bch_syn_tb.sv

// ==== tb/syn_cases.txt ====
// codeword  syn_lo {S4,S3,S2,S1}  syn_hi {S6,S5}  err
// all hex, one test per line, codewords and zero word first
0000 0000 00 0
0537 0000 00 0
0A6E 0000 00 0
0F59 0000 00 0
5370 0000 00 0
7FFF 0000 00 0
// single errors
0001 1111 11 1
0008 FAC8 81 1
0020 6176 17 1
0080 DC9B F6 1
0400 7167 16 1
1000 8CAF F1 1
4000 EFD9 A7 1
1537 8CAF F1 1
// two and three errors
0202 F7C8 67 1
2010 95BE 20 1
4001 FEC8 B6 1
0844 6C76 F1 1
2108 0A00 80 1
1081 4125 16 1
// random words
6D21 86AF 71 1
7B93 1E11 B6 1
1E47 7767 60 1
4C35 0500 21 1
5A93 EED9 B7 1

// ==== tb/bch_syn_tb.sv ====
`timescale 1ns/10ps

module bch_syn_tb;
	import bch_syn_pkg::*;

	localparam int max_cases = 64;

	logic clk;
	logic rst_n;
	logic wb_cyc;
	logic wb_stb;
	logic wb_we;
	logic [1:0] wb_adr;
	logic [15:0] wb_dat_w;
	logic [15:0] wb_dat_r;
	logic wb_ack;
	logic exp_valid;
	logic [15:0] exp_cw;
	logic [15:0] exp_status;
	logic [15:0] exp_lo;
	logic [15:0] exp_hi;
	logic run_chk;
	logic test_end;
	int test_id;
	int pass_count;
	int fail_count;
	int n_cases;
	logic [15:0] case_mem [4*max_cases];         // codeword, syn_lo, syn_hi, err per case

	bch_syn_top UUT (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack)
	);

	syn_checker u_checker (
		.clk(clk),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.exp_valid(exp_valid),
		.exp_cw(exp_cw),
		.exp_status(exp_status),
		.exp_lo(exp_lo),
		.exp_hi(exp_hi),
		.run_chk(run_chk),
		.test_end(test_end),
		.test_id(test_id),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// **********************************************************************
	// the bus master is always entered and left 1 ns after a rising edge
	// **********************************************************************
	task automatic bus_transfer(input logic we, input logic [1:0] adr,
		input logic [15:0] data, output logic [15:0] rdata);
		repeat ($urandom % 4) begin
			@(posedge clk);
			#1;
		end
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we = we;
		wb_adr = adr;
		wb_dat_w = data;
		do begin
			@(posedge clk);
			#1;
		end while (!wb_ack);
		rdata = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		@(posedge clk);                          // the checker samples this edge
		#1;
	endtask

	task automatic wb_write(input logic [1:0] adr, input logic [15:0] data);
		logic [15:0] unused;
		bus_transfer(1'b1, adr, data, unused);
	endtask

	task automatic wb_read(input logic [1:0] adr, output logic [15:0] data);
		bus_transfer(1'b0, adr, 16'h0000, data);
	endtask

	task automatic end_test();
		test_end = 1'b1;
		@(posedge clk);
		#1;
		test_end = 1'b0;
	endtask

	task automatic read_all();
		logic [15:0] rd;
		wb_read(addr_ctrl, rd);
		wb_read(addr_codeword, rd);
		wb_read(addr_syn_lo, rd);
		wb_read(addr_syn_hi, rd);             // after syn_lo so S6 can be checked
	endtask

	// one run that can add a codeword write landing while busy
	task automatic run_case(input logic [15:0] cw, input logic [15:0] lo,
		input logic [15:0] hi, input logic err, input logic intrude);
		logic [15:0] st;
		exp_valid = 1'b0;
		wb_write(addr_codeword, cw);
		wb_write(addr_ctrl, 16'h0001);
		do begin
			wb_read(addr_ctrl, st);
		end while (!st[0]);
		run_chk = 1'b1;
		if (intrude)
			wb_write(addr_codeword, ~cw & 16'h7fff);
		do begin
			wb_read(addr_ctrl, st);
		end while (!st[1]);
		run_chk = 1'b0;
		exp_cw = cw;
		exp_lo = lo;
		exp_hi = hi;
		exp_status = {13'b0, err, 2'b10};
		exp_valid = 1'b1;
		read_all();
		end_test();
	endtask

	// watchdog sized from the number of cases
	initial begin
		#1;
		repeat (n_cases * 40 + 200) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", n_cases * 40 + 200);
		$display("Regression failed");
		$finish;
	end

	initial begin
		int seed;
		seed = $urandom(32'h8646_5c36);
		rst_n = 1'b0;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we = 1'b0;
		wb_adr = 2'd0;
		wb_dat_w = 16'h0000;
		exp_valid = 1'b0;
		exp_cw = 16'h0000;
		exp_status = 16'h0000;
		exp_lo = 16'h0000;
		exp_hi = 16'h0000;
		run_chk = 1'b0;
		test_end = 1'b0;
		test_id = 0;
		$readmemh("tb/syn_cases.txt", case_mem);
		n_cases = 0;
		while (n_cases < max_cases && !$isunknown(case_mem[4*n_cases]))
			n_cases++;
		repeat (16) @(posedge clk);
		#1;
		rst_n = 1'b1;

		exp_valid = 1'b1;                        // everything reads zero after reset
		read_all();
		end_test();
		for (int i = 0; i < n_cases; i++) begin
			test_id = i + 1;
			run_case(case_mem[4*i], case_mem[4*i+1], case_mem[4*i+2], case_mem[4*i+3][0], 1'b0);
		end
		if (n_cases > 0) begin
			test_id = n_cases + 1;
			run_case(case_mem[4*n_cases-4], case_mem[4*n_cases-3], case_mem[4*n_cases-2],
				case_mem[4*n_cases-1][0], 1'b1);
		end else begin
			$display("no test cases could be read from tb/syn_cases.txt");
		end

		$display("tests passed %0d, failed %0d", pass_count, fail_count);
		if (fail_count == 0 && n_cases > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// ==== tb/syn_checker.sv ====
`timescale 1ns/10ps

module syn_checker (
	input logic clk,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [15:0] wb_dat_r,
	input logic wb_ack,
	input logic exp_valid,                       // compare reads with the posted values
	input logic [15:0] exp_cw,
	input logic [15:0] exp_status,
	input logic [15:0] exp_lo,
	input logic [15:0] exp_hi,
	input logic run_chk,                         // a run is under way and was seen busy
	input logic test_end,
	input int test_id,
	output int pass_count,
	output int fail_count
);
	import bch_syn_pkg::*;

	int test_errs;
	logic [15:0] last_lo;                        // S3 for the S6 check
	logic [15:0] expected;

	// squaring over x^4 + x + 1 is linear, a^2 = a0 + a1 alpha^2 + a2 alpha^4 + a3 alpha^6
	function automatic logic [3:0] gf_square(input logic [3:0] a);
		return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
	endfunction

	task automatic report_mismatch(input string what, input logic [15:0] got,
		input logic [15:0] want);
		$display("mismatch at %0t: %s got %h expected %h", $time, what, got, want);
		test_errs++;
	endtask

	initial begin
		pass_count = 0;
		fail_count = 0;
		test_errs = 0;
		last_lo = '0;
	end

	// **********************************************************************
	// read data is sampled on the edge that closes the ack cycle
	// **********************************************************************
	always @(posedge clk) begin
		if (wb_ack && !wb_we) begin
			case (wb_adr)
				addr_codeword: expected = exp_cw;
				addr_ctrl: expected = exp_status;
				addr_syn_lo: expected = exp_lo;
				default: expected = exp_hi;
			endcase
			if (exp_valid && wb_dat_r !== expected)
				report_mismatch($sformatf("addr %0d", wb_adr), wb_dat_r, expected);
			if (wb_adr == addr_ctrl && run_chk && wb_dat_r[0] && wb_dat_r[1])
				report_mismatch("status while busy", wb_dat_r, {wb_dat_r[15:2], 2'b01});
			if (wb_adr == addr_syn_lo) begin
				if (wb_dat_r[7:4] !== gf_square(wb_dat_r[3:0]))
					report_mismatch("S2 against S1 squared", wb_dat_r[7:4], gf_square(wb_dat_r[3:0]));
				if (wb_dat_r[15:12] !== gf_square(wb_dat_r[7:4]))
					report_mismatch("S4 against S2 squared", wb_dat_r[15:12], gf_square(wb_dat_r[7:4]));
				last_lo = wb_dat_r;
			end
			if (wb_adr == addr_syn_hi && wb_dat_r[7:4] !== gf_square(last_lo[11:8]))
				report_mismatch("S6 against S3 squared", wb_dat_r[7:4], gf_square(last_lo[11:8]));
		end
		if (test_end) begin
			if (test_errs == 0) begin
				pass_count++;
				$display("test %0d ok", test_id);
			end else begin
				fail_count++;
				$display("test %0d failed with %0d mismatches", test_id, test_errs);
			end
			test_errs = 0;
		end
	end

endmodule

// ==== hw/bch_syn_top.sv ====
`timescale 1ns/10ps

module bch_syn_top (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [bch_syn_pkg::wb_dw-1:0] wb_dat_w,
	output logic [bch_syn_pkg::wb_dw-1:0] wb_dat_r,
	output logic wb_ack
);

	logic go;
	logic [14:0] codeword;
	logic busy;
	logic bit_start;
	logic bit_en;
	logic bit_data;
	logic last_bit;
	logic [15:0] syn_lo;
	logic [7:0] syn_hi;
	logic err;
	logic done;

	syn_wb_regs u_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wb_cyc(wb_cyc),
		.wb_stb(wb_stb),
		.wb_we(wb_we),
		.wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w),
		.wb_dat_r(wb_dat_r),
		.wb_ack(wb_ack),
		.busy(busy),
		.done(done),
		.err(err),
		.syn_lo(syn_lo),
		.syn_hi(syn_hi),
		.go(go),
		.codeword(codeword)
	);

	codeword_shifter u_shifter (
		.clk(clk),
		.rst_n(rst_n),
		.go(go),
		.codeword(codeword),
		.bit_start(bit_start),
		.bit_en(bit_en),
		.bit_data(bit_data),
		.last_bit(last_bit),
		.busy(busy)
	);

	syn_bank u_bank (
		.clk(clk),
		.rst_n(rst_n),
		.bit_start(bit_start),
		.bit_en(bit_en),
		.bit_data(bit_data),
		.last_bit(last_bit),
		.syn_lo(syn_lo),
		.syn_hi(syn_hi),
		.err(err),
		.done(done)
	);

endmodule

// ==== hw/syn_wb_regs.sv ====
`timescale 1ns/10ps

module syn_wb_regs (
	input logic clk,
	input logic rst_n,
	input logic wb_cyc,
	input logic wb_stb,
	input logic wb_we,
	input logic [1:0] wb_adr,
	input logic [bch_syn_pkg::wb_dw-1:0] wb_dat_w,
	output logic [bch_syn_pkg::wb_dw-1:0] wb_dat_r,
	output logic wb_ack,
	input logic busy,
	input logic done,
	input logic err,
	input logic [15:0] syn_lo,
	input logic [7:0] syn_hi,
	output logic go,
	output logic [14:0] codeword
);
	import bch_syn_pkg::*;

	logic req;                                   // new request this cycle
	logic wr;
	logic start_wr;
	logic [wb_dw-1:0] rd_mux;

	// the ack cycle itself is not a new request, so ack never repeats
	assign req = wb_cyc & wb_stb & ~wb_ack;
	assign wr = req & wb_we;
	assign start_wr = wr && wb_adr == addr_ctrl && wb_dat_w[0];

	// **********************************************************************
	// register writes
	// **********************************************************************
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			go <= 1'b0;
			codeword <= '0;
		end else begin
			wb_ack <= req;
			go <= start_wr & ~busy;              // a start during a run is dropped
			if (wr && wb_adr == addr_codeword && !busy)
				codeword <= wb_dat_w[code_n-1:0];
		end
	end

	// **********************************************************************
	// read data
	// **********************************************************************
	always_comb begin
		case (wb_adr)
			addr_codeword: rd_mux = {1'b0, codeword};
			addr_ctrl: rd_mux = {13'b0, err, done, busy};
			addr_syn_lo: rd_mux = syn_lo;
			default: rd_mux = {8'b0, syn_hi};
		endcase
	end

	always_ff @(posedge clk) begin
		if (req && !wb_we)
			wb_dat_r <= rd_mux;                  // valid in the ack cycle
	end

	// single wait state, then the master must drop stb
	a_ack_single: assert property (@(posedge clk) disable iff (!rst_n)
		wb_ack |=> !wb_ack)
		else $error("syn_wb_regs: ack held for two cycles");

endmodule

// ==== hw/codeword_shifter.sv ====
`timescale 1ns/10ps

module codeword_shifter (
	input logic clk,
	input logic rst_n,
	input logic go,                              // one-cycle start pulse
	input logic [14:0] codeword,
	output logic bit_start,
	output logic bit_en,
	output logic bit_data,
	output logic last_bit,
	output logic busy
);
	import bch_syn_pkg::*;

	logic [code_n-1:0] sh;                       // word, highest coefficient on top
	logic [3:0] cnt;                             // coefficients still to send after this one

	assign bit_data = sh[code_n-1];
	assign busy = bit_start | bit_en;

	// payload shift register
	always_ff @(posedge clk) begin
		if (go) begin
			sh <= codeword;
		end else if (busy && cnt != 4'd0) begin
			sh <= {sh[code_n-2:0], 1'b0};
		end
	end

	// strobes: bit_start once, then bit_en for the remaining 14 coefficients
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			bit_start <= 1'b0;
			bit_en <= 1'b0;
			last_bit <= 1'b0;
			cnt <= 4'd0;
		end else begin
			bit_start <= go;
			if (go) begin
				bit_en <= 1'b0;
				last_bit <= 1'b0;
				cnt <= 4'(code_n - 1);
			end else if (busy && cnt != 4'd0) begin
				bit_en <= 1'b1;
				last_bit <= (cnt == 4'd1);       // coefficient 0 goes out next
				cnt <= cnt - 4'd1;
			end else begin
				bit_en <= 1'b0;
				last_bit <= 1'b0;
			end
		end
	end

	// the register block holds back a start while a run is in progress
	a_go_idle: assert property (@(posedge clk) disable iff (!rst_n)
		go |-> !busy)
		else $error("codeword_shifter: go while busy");

endmodule

// ==== hw/syn_bank.sv ====
`timescale 1ns/10ps

module syn_bank (
	input logic clk,
	input logic rst_n,
	input logic bit_start,
	input logic bit_en,
	input logic bit_data,
	input logic last_bit,                        // marks the final coefficient
	output logic [15:0] syn_lo,                  // {S4, S3, S2, S1}
	output logic [7:0] syn_hi,                   // {S6, S5}
	output logic err,
	output logic done
);
	import bch_syn_pkg::*;

	logic [gf_m-1:0] rem [3];
	logic [gf_m-1:0] syn_odd [3];                // S1, S3, S5
	logic [gf_m-1:0] s2;
	logic [gf_m-1:0] s4;
	logic [gf_m-1:0] s6;
	logic last_q;                                // remainders hold the whole word

	// **********************************************************************
	// odd syndromes by division and evaluation
	// **********************************************************************
	for (genvar i = 0; i < 3; i++) begin : g_odd
		syn_remainder #(
			.syn_idx(2 * i + 1)
		) u_rem (
			.clk(clk),
			.rst_n(rst_n),
			.bit_start(bit_start),
			.bit_en(bit_en),
			.bit_data(bit_data),
			.rem(rem[i])
		);

		syn_expand #(
			.syn_idx(2 * i + 1)
		) u_exp (
			.rem(rem[i]),
			.syn(syn_odd[i])
		);
	end

	// even syndromes follow from squaring in characteristic two
	assign s2 = gf_mult(syn_odd[0], syn_odd[0]);
	assign s4 = gf_mult(s2, s2);
	assign s6 = gf_mult(syn_odd[1], syn_odd[1]);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_q <= 1'b0;
			syn_lo <= '0;
			syn_hi <= '0;
			err <= 1'b0;
			done <= 1'b0;
		end else begin
			last_q <= last_bit;
			if (last_q) begin
				syn_lo <= {s4, syn_odd[1], s2, syn_odd[0]};
				syn_hi <= {s6, syn_odd[2]};
				err <= |{syn_odd[0], syn_odd[1], syn_odd[2], s2, s4, s6};
				done <= 1'b1;                    // sticky until the next run
			end else if (bit_start) begin
				done <= 1'b0;
			end
		end
	end

endmodule

// ==== hw/syn_expand.sv ====
`timescale 1ns/10ps

module syn_expand #(
	parameter int syn_idx = 1
) (
	input logic [bch_syn_pkg::gf_m-1:0] rem,
	output logic [bch_syn_pkg::gf_m-1:0] syn
);
	import bch_syn_pkg::*;

	// **********************************************************************
	// r(alpha^j) as a constant GF(2) matrix times the remainder
	// **********************************************************************
	// each remainder bit k contributes alpha^(k*j), so every output bit is
	// a fixed XOR of some remainder bits
	for (genvar b = 0; b < gf_m; b++) begin : g_row
		localparam logic [gf_m-1:0] row = eval_row(syn_idx, b);

		assign syn[b] = ^(rem & row);  // one XOR tree per output bit
	end

endmodule

// ==== hw/syn_remainder.sv ====
`timescale 1ns/10ps

module syn_remainder #(
	parameter int syn_idx = 1
) (
	input logic clk,
	input logic rst_n,
	input logic bit_start,                       // first coefficient of the word
	input logic bit_en,                          // every following coefficient
	input logic bit_data,
	output logic [bch_syn_pkg::gf_m-1:0] rem
);
	import bch_syn_pkg::*;

	localparam min_poly_t mp = min_poly(syn_idx);
	localparam int deg = mp.deg;
	localparam logic [gf_m-1:0] deg_mask = {gf_m{1'b1}} >> (gf_m - deg);

	logic fb;                                    // bit leaving the top of the remainder
	logic [gf_m-1:0] shifted;

	assign fb = rem[deg-1];
	assign shifted = {rem[gf_m-2:0], bit_data} & deg_mask;  // keep bits above deg clear

	// long division by the minimal polynomial, one received bit per cycle
	always_ff @(posedge clk) begin
		if (bit_start) begin
			rem <= {{(gf_m-1){1'b0}}, bit_data};
		end else if (bit_en) begin
			rem <= shifted ^ (mp.coef & {gf_m{fb}});  // subtract f_j when x^deg appears
		end
	end

	// the shifter must never overlap the load with a shift
	a_start_en_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(bit_start && bit_en))
		else $error("syn_remainder %0d: bit_start and bit_en together", syn_idx);

endmodule

// ==== hw/bch_syn_pkg.sv ====
package bch_syn_pkg;

	// **********************************************************************
	// code and bus constants
	// **********************************************************************
	localparam int gf_m = 4;                       // bits per field element
	localparam int code_n = 15;                    // code length in bits
	localparam int code_t = 3;                     // errors the code corrects
	localparam logic [gf_m:0] gf_prim = 5'b10011;  // x^4 + x + 1

	localparam int wb_dw = 16;                     // wishbone data width

	localparam logic [1:0] addr_codeword = 2'd0;
	localparam logic [1:0] addr_ctrl = 2'd1;
	localparam logic [1:0] addr_syn_lo = 2'd2;
	localparam logic [1:0] addr_syn_hi = 2'd3;

	// minimal polynomial without its leading term, and its degree
	typedef struct packed {
		logic [$clog2(gf_m+1)-1:0] deg;
		logic [gf_m-1:0] coef;
	} min_poly_t;

	// **********************************************************************
	// GF(2^4) arithmetic
	// **********************************************************************
	function automatic logic [gf_m-1:0] gf_mult(input logic [gf_m-1:0] a,
		input logic [gf_m-1:0] b);
		logic [gf_m-1:0] acc;
		logic [gf_m-1:0] sh;
		acc = '0;
		sh = a;
		for (int i = 0; i < gf_m; i++) begin
			if (b[i])
				acc ^= sh;
			sh = {sh[gf_m-2:0], 1'b0} ^ (sh[gf_m-1] ? gf_prim[gf_m-1:0] : '0);  // times alpha
		end
		return acc;
	endfunction

	function automatic logic [gf_m-1:0] gf_pow(input int k);
		logic [gf_m-1:0] e;
		e = 1;
		for (int i = 0; i < (k % code_n); i++)
			e = gf_mult(e, 2);  // alpha is the element x
		return e;
	endfunction

	// product of (x + alpha^(j*2^i)) over the conjugacy class of alpha^j
	function automatic min_poly_t min_poly(input int j);
		logic [gf_m:0][gf_m-1:0] c;
		logic [gf_m-1:0] root;
		logic [gf_m-1:0] first;
		logic fin;
		int deg;
		min_poly_t mp;
		c = '0;
		c[0] = 1;
		deg = 0;
		first = gf_pow(j);
		root = first;
		fin = 1'b0;
		for (int k = 0; k < gf_m; k++) begin
			if (!fin) begin
				for (int i = gf_m; i > 0; i--)
					c[i] = c[i-1] ^ gf_mult(c[i], root);
				c[0] = gf_mult(c[0], root);
				deg++;
				root = gf_mult(root, root);  // next conjugate
				fin = (root == first);
			end
		end
		mp.deg = ($clog2(gf_m+1))'(deg);
		for (int i = 0; i < gf_m; i++)
			mp.coef[i] = (i < deg) && (c[i] != '0);  // coefficients all lie in GF(2)
		return mp;
	endfunction

	// output bit b of r(alpha^j) is the parity of the remainder bits k
	// where alpha^(k*j) has bit b set
	function automatic logic [gf_m-1:0] eval_row(input int j, input int b);
		logic [gf_m-1:0] row;
		logic [gf_m-1:0] p;
		for (int k = 0; k < gf_m; k++) begin
			p = gf_pow(k * j);
			row[k] = p[b];
		end
		return row;
	endfunction

endpackage
